//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run tbBumpy, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tbBumpy -Mdir obj_dir -o simBumpy
	./obj_dir/simBumpy | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- ballIf.sv
interface ballIf import bumpyPkg::*; ();

	motionState state;
	logic collision; // single clock, only on a frame tick
	edgeCode hitEdge;
	neighbourSet area;

	modport fsmSide (
		output state,
		input collision,
		input hitEdge,
		input area
	);

	modport motionSide (
		input state,
		output collision,
		output hitEdge,
		output area
	);

endinterface

//--- bumpyFsm.sv
module bumpyFsm import bumpyPkg::*; #(
	parameter int START_LIVES = 3
) (
	input logic clk,
	input logic resetN,
	input logic [3:0] keys, // {down, right, left, up} active high
	input logic frameStart,
	ballIf.fsmSide bus,
	output lifeCount lives,
	output logic gameOver,
	output logic mapLocked
);

	localparam int KEY_UP    = 0;
	localparam int KEY_LEFT  = 1;
	localparam int KEY_RIGHT = 2;
	localparam int KEY_DOWN  = 3;

	motionState prState;
	motionState nxtState;
	logic upKey;
	logic leftKey;
	logic rightKey;
	logic downKey;
	logic bottomHit;

	assign upKey     = keys[KEY_UP];
	assign leftKey   = keys[KEY_LEFT];
	assign rightKey  = keys[KEY_RIGHT];
	assign downKey   = keys[KEY_DOWN];
	assign bottomHit = bus.collision && (bus.hitEdge == BOTTOM);

	assign bus.state = prState;
	assign mapLocked = (prState != Sreset);

	// common choice after landing on a floor
	function automatic motionState afterBounce(logic up, logic left, logic right);
		motionState next;
		if (up)
			next = Sup;
		else if (left)
			next = Sleft;
		else if (right)
			next = Sright;
		else
			next = Sidle;
		return next;
	endfunction

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			prState <= Sreset;
		else
			prState <= nxtState;
	end

	always_comb begin
		nxtState = prState;
		case (prState)
			Sreset: begin
				if (upKey || leftKey || rightKey || downKey)
					nxtState = Sdown;
			end
			Sidle, SbounceFromLeft, SbounceFromRight, SbounceFromTop: begin
				if (bottomHit)
					nxtState = afterBounce(upKey, leftKey, rightKey);
			end
			Sleft: begin
				if (bottomHit) begin
					if (!upKey && leftKey && bus.area[N_LEFT] == WALL)
						nxtState = SbounceFromLeft;
					else
						nxtState = afterBounce(upKey, leftKey, rightKey);
				end
			end
			Sright: begin
				if (bottomHit) begin
					if (!upKey && !leftKey && rightKey && bus.area[N_RIGHT] == WALL)
						nxtState = SbounceFromRight;
					else
						nxtState = afterBounce(upKey, leftKey, rightKey);
				end
			end
			Sdown: begin
				if (bus.area[N_DOWN] == DEATH)
					nxtState = Sdie;
				else if (bottomHit)
					nxtState = afterBounce(upKey, leftKey, rightKey);
			end
			Sup: begin
				if (bottomHit) begin
					if (upKey && bus.area[N_UP] == WALL)
						nxtState = SbounceFromTop;
					else
						nxtState = afterBounce(upKey, leftKey, rightKey);
				end
			end
			Sdie: begin
				if (frameStart && lives != '0)
					nxtState = Sreset; // respawn
			end
			default: nxtState = Sreset;
		endcase
	end

	// life count and the sticky game over flag
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lives <= lifeCount'(START_LIVES);
			gameOver <= 1'b0;
		end else begin
			if (nxtState == Sdie && prState != Sdie && lives != '0)
				lives <= lives - 3'd1;
			if (prState == Sdie && frameStart && lives == '0)
				gameOver <= 1'b1;
		end
	end

	aStateLegal: assert property (
		@(posedge clk) disable iff (!resetN)
		prState inside {Sreset, Sidle, Sleft, Sright, Sdown, Sup, Sdie,
			SbounceFromLeft, SbounceFromRight, SbounceFromTop}
	);

endmodule

//--- bumpyGame.sv
module bumpyGame import bumpyPkg::*; #(
	parameter int FRAME_CYCLES = 833_333,
	parameter int DEBOUNCE_CYCLES = 50_000,
	parameter int START_LIVES = 3,
	parameter int SPAWN_X = 7,
	parameter int SPAWN_Y = 0
) (
	input logic clk,
	input logic resetN,
	input logic [3:0] keysN, // {down, right, left, up}, active low
	input logic mapWrValid,
	input logic [7:0] mapWrAddr,
	input tileType mapWrData,
	output logic mapWrReady,
	output motionState state,
	output tileCoord posX,
	output tileCoord posY,
	output lifeCount lives,
	output logic gameOver,
	output logic frameStart // to the renderer
);

	ballIf ball ();

	logic [3:0] keys;
	logic mapLocked;
	neighbourSet area;

	assign state = ball.state;

	keySync #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) uKeySync (
		.clk(clk),
		.resetN(resetN),
		.keysN(keysN),
		.keys(keys)
	);

	tileMap uTileMap (
		.clk(clk),
		.resetN(resetN),
		.mapWrValid(mapWrValid),
		.mapWrAddr(mapWrAddr),
		.mapWrData(mapWrData),
		.mapWrReady(mapWrReady),
		.mapLocked(mapLocked),
		.posX(posX),
		.posY(posY),
		.area(area)
	);

	bumpyMotion #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.SPAWN_X(SPAWN_X),
		.SPAWN_Y(SPAWN_Y)
	) uMotion (
		.clk(clk),
		.resetN(resetN),
		.bus(ball),
		.area(area),
		.posX(posX),
		.posY(posY),
		.frameStart(frameStart)
	);

	bumpyFsm #(
		.START_LIVES(START_LIVES)
	) uFsm (
		.clk(clk),
		.resetN(resetN),
		.keys(keys),
		.frameStart(frameStart),
		.bus(ball),
		.lives(lives),
		.gameOver(gameOver),
		.mapLocked(mapLocked)
	);

endmodule

//--- bumpyMotion.sv
module bumpyMotion import bumpyPkg::*; #(
	parameter int FRAME_CYCLES = 8,
	parameter int SPAWN_X = 7,
	parameter int SPAWN_Y = 0
) (
	input logic clk,
	input logic resetN,
	ballIf.motionSide bus,
	input neighbourSet area,
	output tileCoord posX,
	output tileCoord posY,
	output logic frameStart
);

	localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

	logic [CNT_W-1:0] frameCnt;
	logic [1:0] hopLeft; // rows still to rise in a hop
	logic frozen;
	logic falling;
	logic onFloor;
	logic ceiling;
	logic goLeft;
	logic goRight;

	assign bus.area = area;

	assign frameStart = (frameCnt == CNT_W'(FRAME_CYCLES - 1));

	assign frozen  = (bus.state == Sreset) || (bus.state == Sdie);
	assign falling = (hopLeft == 2'd0);
	assign onFloor = area[N_DOWN] inside {REGU, GATE, WALL};
	assign ceiling = (area[N_UP] == WALL);
	assign goLeft  = (bus.state inside {Sleft, SbounceFromRight}) && (area[N_LEFT] != WALL);
	assign goRight = (bus.state inside {Sright, SbounceFromLeft}) && (area[N_RIGHT] != WALL);

	assign bus.collision = frameStart && !frozen && falling && onFloor;

	always_comb begin
		bus.hitEdge = '0;
		if (bus.collision)
			bus.hitEdge = BOTTOM;
		else if (frameStart && !frozen && !falling && ceiling)
			bus.hitEdge = TOP; // head bump ends the hop quietly
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			frameCnt <= '0;
		else if (frameStart)
			frameCnt <= '0;
		else
			frameCnt <= frameCnt + 1'b1;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX <= tileCoord'(SPAWN_X);
			posY <= tileCoord'(SPAWN_Y);
			hopLeft <= 2'd0;
		end else if (frameStart) begin
			if (frozen) begin
				posX <= tileCoord'(SPAWN_X);
				posY <= tileCoord'(SPAWN_Y);
				hopLeft <= 2'd0;
			end else begin
				if (goLeft)
					posX <= posX - 4'd1;
				else if (goRight)
					posX <= posX + 4'd1;

				if (falling) begin
					if (onFloor)
						hopLeft <= (bus.state == Sup) ? 2'd2 : 2'd1; // high jump
					else
						posY <= posY + 4'd1;
				end else if (ceiling) begin
					hopLeft <= 2'd0;
				end else begin
					posY <= posY - 4'd1;
					hopLeft <= hopLeft - 2'd1;
				end
			end
		end
	end

	aCollisionOnTick: assert property (
		@(posedge clk) disable iff (!resetN)
		bus.collision |-> frameStart
	);

endmodule

//--- bumpyPkg.sv
package bumpyPkg;

	// one tile kind
	typedef logic [2:0] tileType;

	localparam tileType FREE  = 3'd0;
	localparam tileType REGU  = 3'd1;
	localparam tileType GATE  = 3'd2; // treated as floor for now
	localparam tileType DEATH = 3'd3;
	localparam tileType WALL  = 3'd4;

	// tile column or row
	typedef logic [3:0] tileCoord;

	// one-hot {Left, Top, Right, Bottom}
	typedef logic [3:0] edgeCode;

	localparam edgeCode BOTTOM = 4'b0001;
	localparam edgeCode RIGHT  = 4'b0010;
	localparam edgeCode TOP    = 4'b0100;
	localparam edgeCode LEFT   = 4'b1000;

	// the four tiles around the ball
	typedef tileType [3:0] neighbourSet;

	localparam int N_LEFT  = 0;
	localparam int N_UP    = 1;
	localparam int N_RIGHT = 2;
	localparam int N_DOWN  = 3;

	typedef enum logic [3:0] {
		Sreset,
		Sidle,
		Sleft,
		Sright,
		Sdown,
		Sup,
		Sdie,
		SbounceFromLeft,
		SbounceFromRight,
		SbounceFromTop
	} motionState;

	typedef logic [2:0] lifeCount;

endpackage

//--- keySync.sv
module keySync #(
	parameter int DEBOUNCE_CYCLES = 3
) (
	input logic clk,
	input logic resetN,
	input logic [3:0] keysN,
	output logic [3:0] keys
);

	localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES + 1) : 1;

	logic [3:0] syncA;
	logic [3:0] syncB;
	logic [3:0] stableN; // debounced level, still active low
	logic [CNT_W-1:0] stableCnt [4];

	assign keys = ~stableN;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			syncA <= 4'hF; // released
			syncB <= 4'hF;
		end else begin
			syncA <= keysN;
			syncB <= syncA;
		end
	end

	// level follows only after DEBOUNCE_CYCLES of a steady new value
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			stableN <= 4'hF;
			for (int i = 0; i < 4; i++) begin
				stableCnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (syncB[i] == stableN[i]) begin
					stableCnt[i] <= '0; // bounce restarts the wait
				end else if (stableCnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					stableN[i] <= syncB[i];
					stableCnt[i] <= '0;
				end else begin
					stableCnt[i] <= stableCnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

//--- sim.f
bumpyPkg.sv
ballIf.sv
keySync.sv
tileMap.sv
bumpyFsm.sv
bumpyMotion.sv
bumpyGame.sv
tbClock.sv
tbBumpy.sv

//--- tbBumpy.sv
module tbBumpy import bumpyPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES = 8;
	localparam int DEBOUNCE_CYCLES = 3;
	localparam int START_LIVES = 3;
	localparam int SPAWN_X = 7;
	localparam int SPAWN_Y = 0;
	localparam int KEY_DELAY = 2 + DEBOUNCE_CYCLES;
	localparam int SCHED_TICKS = 240; // arena, random keys and three deaths
	localparam int WATCH_NS = SCHED_TICKS * FRAME_CYCLES * 4 + 2000;

	logic clk;
	logic resetN;
	logic softResetN;
	logic rstN;
	logic [3:0] keysN;
	logic mapWrValid;
	logic [7:0] mapWrAddr;
	tileType mapWrData;
	logic mapWrReady;
	motionState state;
	tileCoord posX;
	tileCoord posY;
	lifeCount lives;
	logic gameOver;
	logic frameStart;

	tileType mapModel [256];
	logic [3:0] keyPipe [KEY_DELAY]; // raw keys on their way through sync and debounce
	motionState mState;
	int mX;
	int mY;
	int mHop;
	int mLives;
	logic mOver;
	int mCnt;
	logic mTicked;
	int errors = 0;

	assign rstN = resetN && softResetN;

	tbClock clkGen (.clk(clk), .resetN(resetN));

	bumpyGame #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.START_LIVES(START_LIVES),
		.SPAWN_X(SPAWN_X),
		.SPAWN_Y(SPAWN_Y)
	) dut (
		.clk(clk),
		.resetN(rstN),
		.keysN(keysN),
		.mapWrValid(mapWrValid),
		.mapWrAddr(mapWrAddr),
		.mapWrData(mapWrData),
		.mapWrReady(mapWrReady),
		.state(state),
		.posX(posX),
		.posY(posY),
		.lives(lives),
		.gameOver(gameOver),
		.frameStart(frameStart)
	);

	function automatic tileType tileAt(int x, int y);
		if (x < 0 || x > 15 || y < 0 || y > 15)
			return WALL; // outside the border
		return mapModel[y * 16 + x];
	endfunction

	// up key wins over left and right
	function automatic motionState landingState(logic [3:0] k);
		if (k[0])
			return Sup;
		if (k[1])
			return Sleft;
		if (k[2])
			return Sright;
		return Sidle;
	endfunction

	task automatic resetModel();
		for (int i = 0; i < 256; i++)
			mapModel[i] = FREE;
		for (int i = 0; i < KEY_DELAY; i++)
			keyPipe[i] = 4'h0;
		mState = Sreset;
		mX = SPAWN_X;
		mY = SPAWN_Y;
		mHop = 0;
		mLives = START_LIVES;
		mOver = 1'b0;
		mCnt = 0;
		mTicked = 1'b0;
	endtask

	task automatic stepModel();
		logic tick;
		logic landed;
		logic [3:0] k;
		tileType nL;
		tileType nU;
		tileType nR;
		tileType nD;
		motionState nxt;
		tick = (mCnt == FRAME_CYCLES - 1);
		k = keyPipe[KEY_DELAY - 1];
		nL = tileAt(mX - 1, mY);
		nU = tileAt(mX, mY - 1);
		nR = tileAt(mX + 1, mY);
		nD = tileAt(mX, mY + 1);
		landed = tick && mState != Sreset && mState != Sdie && mHop == 0
			&& nD inside {REGU, GATE, WALL};
		nxt = mState;
		case (mState)
			Sreset: begin
				if (k != 4'h0)
					nxt = Sdown;
			end
			Sdown: begin
				if (nD == DEATH)
					nxt = Sdie;
				else if (landed)
					nxt = landingState(k);
			end
			Sleft: begin
				if (landed)
					nxt = (k[1:0] == 2'b10 && nL == WALL) ? SbounceFromLeft : landingState(k);
			end
			Sright: begin
				if (landed)
					nxt = (k[2:0] == 3'b100 && nR == WALL) ? SbounceFromRight : landingState(k);
			end
			Sup: begin
				if (landed)
					nxt = (k[0] && nU == WALL) ? SbounceFromTop : landingState(k);
			end
			Sdie: begin
				if (tick && mLives > 0)
					nxt = Sreset;
			end
			default: begin
				if (landed)
					nxt = landingState(k);
			end
		endcase
		if (tick) begin
			if (mState == Sreset || mState == Sdie) begin
				mX = SPAWN_X;
				mY = SPAWN_Y;
				mHop = 0;
			end else begin
				if ((mState == Sleft || mState == SbounceFromRight) && nL != WALL)
					mX = mX - 1;
				else if ((mState == Sright || mState == SbounceFromLeft) && nR != WALL)
					mX = mX + 1;
				if (mHop == 0) begin
					if (landed)
						mHop = (mState == Sup) ? 2 : 1;
					else
						mY = mY + 1; // rows grow downward
				end else if (nU == WALL) begin
					mHop = 0; // head against the ceiling
				end else begin
					mY = mY - 1;
					mHop = mHop - 1;
				end
			end
		end
		if (mState == Sdie && tick && mLives == 0)
			mOver = 1'b1;
		if (nxt == Sdie && mState != Sdie)
			mLives = mLives - 1;
		if (mapWrValid && mState == Sreset)
			mapModel[mapWrAddr] = mapWrData;
		for (int i = KEY_DELAY - 1; i > 0; i--)
			keyPipe[i] = keyPipe[i - 1];
		keyPipe[0] = ~keysN;
		mState = nxt;
		mCnt = tick ? 0 : mCnt + 1;
		mTicked = tick;
	endtask

	always @(posedge clk) begin
		if (!rstN)
			resetModel();
		else
			stepModel();
	end

	task automatic valueError(input string sig, input int got, input int want);
		$display("error %s: got 0x%0h, expected 0x%0h at %0t", sig, got, want, $time);
		errors++;
	endtask

	always @(negedge clk) begin
		if (rstN) begin
			if (frameStart !== (mCnt == FRAME_CYCLES - 1))
				valueError("frameStart", frameStart, mCnt == FRAME_CYCLES - 1);
			if (mapWrReady !== (mState == Sreset))
				valueError("mapWrReady", mapWrReady, mState == Sreset);
			if (mTicked) begin // one clock after the tick
				if (state !== mState)
					valueError("state", state, mState);
				if (posX !== tileCoord'(mX))
					valueError("posX", posX, mX);
				if (posY !== tileCoord'(mY))
					valueError("posY", posY, mY);
				if (lives !== lifeCount'(mLives))
					valueError("lives", lives, mLives);
				if (gameOver !== mOver)
					valueError("gameOver", gameOver, mOver);
			end
		end
	end

	task automatic writeTile(input int x, input int y, input tileType t);
		int waited;
		waited = 0;
		mapWrValid <= 1'b1;
		mapWrAddr <= 8'(y * 16 + x);
		mapWrData <= t;
		while (!mapWrReady && waited < 4 * FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!mapWrReady) begin
			$display("map write to tile (%0d, %0d) was never accepted", x, y);
			errors++;
		end
		@(negedge clk);
		mapWrValid <= 1'b0;
	endtask

	task automatic holdKeys(input logic [3:0] pressed, input int ticks);
		keysN <= ~pressed;
		repeat (ticks * FRAME_CYCLES) @(negedge clk);
	endtask

	task automatic waitForState(input motionState target, input int ticks);
		int waited;
		waited = 0;
		while (state != target && waited < ticks * FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (state != target) begin
			$display("state %s not reached within %0d ticks", target.name(), ticks);
			errors++;
		end
	endtask

	task automatic reportAndFinish();
		$display("tbBumpy done, %0d errors", errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	initial begin
		#(WATCH_NS);
		$display("watchdog expired after %0d ns, the run did not complete", WATCH_NS);
		errors++;
		reportAndFinish();
	end

	initial begin
		int floorRow;
		int deathRow;
		int lastRow;
		logic [3:0] pick;
		keysN = 4'hF;
		mapWrValid = 1'b0;
		mapWrAddr = 8'h00;
		mapWrData = FREE;
		softResetN = 1'b1;
		void'($urandom(32'hd578));
		@(posedge resetN);
		@(negedge clk);

		holdKeys(4'h0, 3); // ball waits at spawn without a key
		floorRow = 8 + $urandom % 6;
		for (int x = 0; x < 16; x++)
			writeTile(x, floorRow, REGU);
		for (int x = 0; x < 7; x++)
			writeTile(x, floorRow - 3, WALL); // ceiling clear of the spawn column
		writeTile($urandom % 6, floorRow - 1, ($urandom % 2) ? WALL : DEATH);

		holdKeys(4'b0001, 16);
		holdKeys(4'b0010, 24); // runs into the left wall
		holdKeys(4'b0001, 12); // high jump under the ceiling
		for (int i = 0; i < 20; i++)
			holdKeys(4'($urandom), 4);
		holdKeys(4'h0, 4);

		// fresh game for the life count
		softResetN <= 1'b0;
		repeat (3) @(negedge clk);
		softResetN <= 1'b1;
		@(negedge clk);
		lastRow = 0;
		for (int d = 0; d < START_LIVES; d++) begin
			deathRow = 3 + $urandom % 13;
			if (lastRow != 0)
				writeTile(SPAWN_X, lastRow, FREE);
			writeTile(SPAWN_X, deathRow, DEATH);
			lastRow = deathRow;
			pick = 4'b0001 << ($urandom % 4);
			holdKeys(pick, 1);
			holdKeys(4'h0, 0);
			waitForState(Sdie, 20);
			if (d < START_LIVES - 1)
				waitForState(Sreset, 3);
			else
				holdKeys(4'h0, 3);
		end
		if (!gameOver || state != Sdie) begin
			$display("game over not reached after %0d deaths", START_LIVES);
			errors++;
		end
		reportAndFinish();
	end

endmodule

//--- tbClock.sv
module tbClock #(
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic resetN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		resetN = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		resetN <= 1'b1;
	end

endmodule

//--- tileMap.sv
module tileMap import bumpyPkg::*; (
	input logic clk,
	input logic resetN,
	input logic mapWrValid,
	input logic [7:0] mapWrAddr, // {row, column}
	input tileType mapWrData,
	output logic mapWrReady,
	input logic mapLocked,
	input tileCoord posX,
	input tileCoord posY,
	output neighbourSet area
);

	tileType tiles [256];
	logic wrFire;
	logic [7:0] leftAddr;
	logic [7:0] upAddr;
	logic [7:0] rightAddr;
	logic [7:0] downAddr;

	// editing is allowed only while the ball waits at spawn
	assign mapWrReady = !mapLocked;
	assign wrFire = mapWrValid && mapWrReady;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < 256; i++) begin
				tiles[i] <= FREE;
			end
		end else if (wrFire) begin
			tiles[mapWrAddr] <= mapWrData;
		end
	end

	assign leftAddr  = {posY, posX - 4'd1};
	assign upAddr    = {posY - 4'd1, posX};
	assign rightAddr = {posY, posX + 4'd1};
	assign downAddr  = {posY + 4'd1, posX};

	// off-map neighbours look like solid wall
	always_comb begin
		area[N_LEFT]  = (posX == 4'd0)  ? WALL : tiles[leftAddr];
		area[N_UP]    = (posY == 4'd0)  ? WALL : tiles[upAddr];
		area[N_RIGHT] = (posX == 4'd15) ? WALL : tiles[rightAddr];
		area[N_DOWN]  = (posY == 4'd15) ? WALL : tiles[downAddr];
	end

	// map content is frozen while the game runs
	aNoWriteLocked: assert property (
		@(posedge clk) disable iff (!resetN)
		mapLocked |=> tiles[$past(mapWrAddr)] == $past(tiles[mapWrAddr])
	);

endmodule
